/* common/stq_config.svh */
`ifndef STQ_CONFIG_SVH
`define STQ_CONFIG_SVH

// queue depth, must be a power of two for the pointer wrap
`define STQ_ENTRIES 16

// store data word
`define STQ_DATA_W 32

// word address, byte offset already stripped
`define STQ_ADDR_W 30

// write buffer slots on the cache side
`define STQ_DRAIN_CREDITS 4

`endif

/* common/stq_pkg.sv */
`include "stq_config.svh"

package stq_pkg;

  // one full store word
  typedef logic [`STQ_DATA_W-1:0] stq_data_t;

  // word address of a store or load
  typedef logic [`STQ_ADDR_W-1:0] stq_addr_t;

  // position inside the queue
  typedef logic [$clog2(`STQ_ENTRIES)-1:0] stq_idx_t;

  // one bit per entry, used for selects and status flags
  typedef logic [`STQ_ENTRIES-1:0] stq_mask_t;

  // wide enough to hold the full credit count
  typedef logic [$clog2(`STQ_DRAIN_CREDITS+1)-1:0] stq_credit_t;

endpackage

/* common/stq_drain_if.sv */
`timescale 1ns/1ps

// oldest committed store, handed from queue control to the drain port
interface stq_drain_if;
  import stq_pkg::*;

  logic      head_valid;  // head is committed and written
  stq_addr_t head_addr;
  stq_data_t head_data;
  logic      take;        // retires the head this cycle

  // queue side
  modport ctrl (
    output head_valid,
    output head_addr,
    output head_data,
    input  take
  );

  // drain side, owns the credits
  modport drain (
    input  head_valid,
    input  head_addr,
    input  head_data,
    output take
  );

endinterface

/* stq/stq_data_array.sv */
`timescale 1ns/1ps

`include "stq_config.svh"

// store data storage, one register per entry
// two one-hot write ports, three one-hot check ports (port 2 feeds the drain head)
module stq_data_array (
  input  logic               clk,
  input  logic               rst_n,
  input  stq_pkg::stq_mask_t wr0_sel,
  input  stq_pkg::stq_data_t wr0_data,
  input  stq_pkg::stq_mask_t wr1_sel,
  input  stq_pkg::stq_data_t wr1_data,
  input  stq_pkg::stq_mask_t chk0_sel,
  output stq_pkg::stq_data_t chk0_data,
  input  stq_pkg::stq_mask_t chk1_sel,
  output stq_pkg::stq_data_t chk1_data,
  input  stq_pkg::stq_mask_t chk2_sel,
  output stq_pkg::stq_data_t chk2_data
);
  import stq_pkg::*;

  stq_data_t entry_q [`STQ_ENTRIES];

  genvar e;
  generate
    for (e = 0; e < `STQ_ENTRIES; e++) begin : g_entry
      always_ff @(posedge clk) begin
        if (wr0_sel[e]) entry_q[e] <= wr0_data;
        if (wr1_sel[e]) entry_q[e] <= wr1_data; // port 1 wins on collision
      end
    end
  endgenerate

  // and-or read, zero when nothing is selected
  function automatic stq_data_t read_sel(input stq_mask_t sel);
    stq_data_t acc;
    acc = '0;
    for (int i = 0; i < `STQ_ENTRIES; i++) begin
      acc |= entry_q[i] & {`STQ_DATA_W{sel[i]}};
    end
    return acc;
  endfunction

  always_comb begin
    chk0_data = read_sel(chk0_sel);
    chk1_data = read_sel(chk1_sel);
    chk2_data = read_sel(chk2_sel);  // head read
  end

  // more than one hot bit would OR two entries together
  a_wr0_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(wr0_sel));
  a_wr1_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(wr1_sel));
  a_chk0_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(chk0_sel));
  a_chk1_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(chk1_sel));
  a_chk2_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(chk2_sel));

endmodule

/* stq/stq_ctrl.sv */
`timescale 1ns/1ps

`include "stq_config.svh"

// store queue control: pointers, entry status, address tags,
// forwarding match and head presentation toward the drain
module stq_ctrl (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               alloc,
  output stq_pkg::stq_idx_t  alloc_idx,
  output logic               full,
  input  logic               wr0_en,
  input  stq_pkg::stq_idx_t  wr0_idx,
  input  stq_pkg::stq_addr_t wr0_addr,
  input  logic               wr1_en,
  input  stq_pkg::stq_idx_t  wr1_idx,
  input  stq_pkg::stq_addr_t wr1_addr,
  input  logic               commit,
  input  stq_pkg::stq_addr_t ld0_addr,
  input  stq_pkg::stq_addr_t ld1_addr,
  output logic               ld0_hit,
  output logic               ld1_hit,
  output stq_pkg::stq_mask_t wr0_sel,
  output stq_pkg::stq_mask_t wr1_sel,
  output stq_pkg::stq_mask_t chk0_sel,
  output stq_pkg::stq_mask_t chk1_sel,
  output stq_pkg::stq_mask_t chk2_sel,
  input  stq_pkg::stq_data_t chk0_data,
  input  stq_pkg::stq_data_t chk1_data,
  input  stq_pkg::stq_data_t chk2_data,
  stq_drain_if.ctrl          drain
);
  import stq_pkg::*;

  localparam int IW = $bits(stq_idx_t);
  typedef logic [IW:0] ptr_t; // msb is the wrap bit

  ptr_t      tail_q, cmt_q, head_q;
  stq_mask_t valid_q;
  stq_mask_t written_q;
  stq_mask_t committed_q;
  stq_addr_t tag_q [`STQ_ENTRIES];

  stq_idx_t  head_idx;
  logic      alloc_ok;
  stq_mask_t alloc_mask, commit_mask, take_mask;

  assign head_idx  = head_q[IW-1:0];
  assign alloc_idx = tail_q[IW-1:0];
  assign full      = (tail_q[IW] != head_q[IW]) && (tail_q[IW-1:0] == head_idx);
  assign alloc_ok  = alloc && !full;

  assign alloc_mask  = alloc_ok ? stq_mask_t'(1) << tail_q[IW-1:0] : '0;
  assign commit_mask = commit ? stq_mask_t'(1) << cmt_q[IW-1:0] : '0;
  assign take_mask   = drain.take ? stq_mask_t'(1) << head_idx : '0;

  // index decode for the data array
  assign wr0_sel = wr0_en ? stq_mask_t'(1) << wr0_idx : '0;
  assign wr1_sel = wr1_en ? stq_mask_t'(1) << wr1_idx : '0;

  // walk from head toward tail, later hits are younger and replace earlier ones
  function automatic stq_mask_t youngest_match(input stq_addr_t addr);
    stq_mask_t sel;
    stq_idx_t  idx;
    sel = '0;
    for (int k = 0; k < `STQ_ENTRIES; k++) begin
      idx = head_idx + stq_idx_t'(k);
      if (valid_q[idx] && written_q[idx] && (tag_q[idx] == addr)) begin
        sel      = '0;
        sel[idx] = 1'b1;
      end
    end
    return sel;
  endfunction

  always_comb begin
    chk0_sel = youngest_match(ld0_addr);
    chk1_sel = youngest_match(ld1_addr);
  end

  assign ld0_hit = |chk0_sel;
  assign ld1_hit = |chk1_sel;

  // head goes out once committed and its data has arrived
  assign chk2_sel         = stq_mask_t'(1) << head_idx;
  assign drain.head_valid = valid_q[head_idx] && written_q[head_idx] && committed_q[head_idx];
  assign drain.head_addr  = tag_q[head_idx];
  assign drain.head_data  = chk2_data;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tail_q      <= '0;
      cmt_q       <= '0;
      head_q      <= '0;
      valid_q     <= '0;
      written_q   <= '0;
      committed_q <= '0;
    end else begin
      if (alloc_ok) tail_q <= tail_q + 1'b1;
      if (commit) cmt_q <= cmt_q + 1'b1;
      if (drain.take) head_q <= head_q + 1'b1;
      valid_q     <= (valid_q & ~take_mask) | alloc_mask;
      written_q   <= (written_q & ~alloc_mask) | wr0_sel | wr1_sel;
      committed_q <= (committed_q & ~alloc_mask) | commit_mask;
    end
  end

  // address tags, port 1 last so it wins
  always_ff @(posedge clk) begin
    if (wr0_en) tag_q[wr0_idx] <= wr0_addr;
    if (wr1_en) tag_q[wr1_idx] <= wr1_addr;
  end

  a_no_alloc_full: assert property (@(posedge clk) disable iff (!rst_n)
    alloc |-> !full);
  a_commit_in_range: assert property (@(posedge clk) disable iff (!rst_n)
    commit |-> (cmt_q != tail_q));
  a_wr0_valid: assert property (@(posedge clk) disable iff (!rst_n)
    wr0_en |-> valid_q[wr0_idx]);
  a_wr1_valid: assert property (@(posedge clk) disable iff (!rst_n)
    wr1_en |-> valid_q[wr1_idx]);

endmodule

/* rtl/stq_drain.sv */
`timescale 1ns/1ps

`include "stq_config.svh"

// drain port toward the cache
// take is combinational, the store goes out registered one cycle later
module stq_drain (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               cache_credit,
  output logic               cache_valid,
  output stq_pkg::stq_addr_t cache_addr,
  output stq_pkg::stq_data_t cache_data,
  stq_drain_if.drain         drain
);
  import stq_pkg::*;

  localparam stq_credit_t MAX_CREDITS = stq_credit_t'(`STQ_DRAIN_CREDITS);

  stq_credit_t credit_q;
  stq_credit_t credit_nxt;

  // one slot per store in flight
  assign drain.take = drain.head_valid && (credit_q != '0);

  always_comb begin
    credit_nxt = credit_q;
    if (drain.take) credit_nxt = credit_nxt - 1'b1;
    if (cache_credit) credit_nxt = credit_nxt + 1'b1; // slot freed by the cache
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      credit_q    <= MAX_CREDITS;
      cache_valid <= 1'b0;
    end else begin
      credit_q    <= credit_nxt;
      cache_valid <= drain.take;
    end
  end

  // payload only moves with take
  always_ff @(posedge clk) begin
    if (drain.take) begin
      cache_addr <= drain.head_addr;
      cache_data <= drain.head_data;
    end
  end

  // cache must not return more credits than it has slots
  a_credit_max: assert property (@(posedge clk) disable iff (!rst_n)
    credit_q <= MAX_CREDITS);

endmodule

/* rtl/stq_top.sv */
`timescale 1ns/1ps

// store queue top level
module stq_top (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               alloc,
  output stq_pkg::stq_idx_t  alloc_idx,
  output logic               full,
  input  logic               wr0_en,
  input  stq_pkg::stq_idx_t  wr0_idx,
  input  stq_pkg::stq_addr_t wr0_addr,
  input  stq_pkg::stq_data_t wr0_data,
  input  logic               wr1_en,
  input  stq_pkg::stq_idx_t  wr1_idx,
  input  stq_pkg::stq_addr_t wr1_addr,
  input  stq_pkg::stq_data_t wr1_data,
  input  logic               commit,
  input  stq_pkg::stq_addr_t ld0_addr,
  output logic               ld0_hit,
  output stq_pkg::stq_data_t ld0_data,
  input  stq_pkg::stq_addr_t ld1_addr,
  output logic               ld1_hit,
  output stq_pkg::stq_data_t ld1_data,
  output logic               cache_valid,
  output stq_pkg::stq_addr_t cache_addr,
  output stq_pkg::stq_data_t cache_data,
  input  logic               cache_credit
);
  import stq_pkg::*;

  stq_mask_t wr0_sel, wr1_sel;
  stq_mask_t chk0_sel, chk1_sel, chk2_sel;
  stq_data_t head_rd_data;

  stq_drain_if drain_bus ();

  stq_ctrl u_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .alloc     (alloc),
    .alloc_idx (alloc_idx),
    .full      (full),
    .wr0_en    (wr0_en),
    .wr0_idx   (wr0_idx),
    .wr0_addr  (wr0_addr),
    .wr1_en    (wr1_en),
    .wr1_idx   (wr1_idx),
    .wr1_addr  (wr1_addr),
    .commit    (commit),
    .ld0_addr  (ld0_addr),
    .ld1_addr  (ld1_addr),
    .ld0_hit   (ld0_hit),
    .ld1_hit   (ld1_hit),
    .wr0_sel   (wr0_sel),
    .wr1_sel   (wr1_sel),
    .chk0_sel  (chk0_sel),
    .chk1_sel  (chk1_sel),
    .chk2_sel  (chk2_sel),
    .chk0_data (ld0_data),
    .chk1_data (ld1_data),
    .chk2_data (head_rd_data),
    .drain     (drain_bus.ctrl)
  );

  // load data comes straight off the array, zero on a miss
  stq_data_array u_data (
    .clk       (clk),
    .rst_n     (rst_n),
    .wr0_sel   (wr0_sel),
    .wr0_data  (wr0_data),
    .wr1_sel   (wr1_sel),
    .wr1_data  (wr1_data),
    .chk0_sel  (chk0_sel),
    .chk0_data (ld0_data),
    .chk1_sel  (chk1_sel),
    .chk1_data (ld1_data),
    .chk2_sel  (chk2_sel),
    .chk2_data (head_rd_data)
  );

  stq_drain u_drain (
    .clk          (clk),
    .rst_n        (rst_n),
    .cache_credit (cache_credit),
    .cache_valid  (cache_valid),
    .cache_addr   (cache_addr),
    .cache_data   (cache_data),
    .drain        (drain_bus.drain)
  );

endmodule

/* verification/stq_tb.sv */
`timescale 1ns/1ps

`include "stq_config.svh"

module stq_tb;
  import stq_pkg::*;

  typedef struct packed {
    logic      alloc;
    logic      commit;
    logic      wr0_en;
    stq_idx_t  wr0_idx;
    stq_addr_t wr0_addr;
    stq_data_t wr0_data;
    logic      wr1_en;
    stq_idx_t  wr1_idx;
    stq_addr_t wr1_addr;
    stq_data_t wr1_data;
    stq_addr_t ld0_addr;
    logic      ld0_hit;
    stq_data_t ld0_data;
    stq_addr_t ld1_addr;
    logic      ld1_hit;
    stq_data_t ld1_data;
  } row_t;

  localparam int NUM_ROWS = 15;

  localparam stq_addr_t ADR_X = 30'h100;
  localparam stq_addr_t ADR_Y = 30'h200;
  localparam stq_addr_t ADR_N = 30'h300;  // never written
  localparam stq_addr_t ADR_Z = 30'h400;
  localparam stq_data_t DAT_A = 32'h1111_0001;
  localparam stq_data_t DAT_B = 32'h2222_0002;
  localparam stq_data_t DAT_C = 32'h3333_0003;
  localparam stq_data_t DAT_D = 32'h4444_0004;
  localparam stq_data_t DAT_E = 32'h5555_0005;

  // alloc commit | wr0 en idx addr data | wr1 en idx addr data
  //   ld0 addr hit data | ld1 addr hit data
  row_t rows [NUM_ROWS] = '{
    '{1'b0, 1'b0, 1'b0, 4'd0, '0, '0, 1'b0, 4'd0, '0, '0,
      ADR_X, 1'b0, '0, ADR_Y, 1'b0, '0},
    '{1'b1, 1'b0, 1'b0, 4'd0, '0, '0, 1'b0, 4'd0, '0, '0,
      ADR_X, 1'b0, '0, ADR_Y, 1'b0, '0},
    '{1'b1, 1'b0, 1'b0, 4'd0, '0, '0, 1'b0, 4'd0, '0, '0,
      ADR_X, 1'b0, '0, ADR_Y, 1'b0, '0},
    '{1'b1, 1'b0, 1'b0, 4'd0, '0, '0, 1'b0, 4'd0, '0, '0,
      ADR_X, 1'b0, '0, ADR_Y, 1'b0, '0},
    '{1'b1, 1'b0, 1'b0, 4'd0, '0, '0, 1'b0, 4'd0, '0, '0,
      ADR_X, 1'b0, '0, ADR_Y, 1'b0, '0},
    // writes land at the edge, loads in the same row still miss
    '{1'b0, 1'b0, 1'b1, 4'd0, ADR_X, DAT_A, 1'b1, 4'd1, ADR_Y, DAT_B,
      ADR_X, 1'b0, '0, ADR_Y, 1'b0, '0},
    '{1'b0, 1'b0, 1'b0, 4'd0, '0, '0, 1'b0, 4'd0, '0, '0,
      ADR_X, 1'b1, DAT_A, ADR_N, 1'b0, '0},
    '{1'b0, 1'b0, 1'b1, 4'd2, ADR_X, DAT_C, 1'b0, 4'd0, '0, '0,
      ADR_X, 1'b1, DAT_A, ADR_Y, 1'b1, DAT_B},
    '{1'b0, 1'b0, 1'b0, 4'd0, '0, '0, 1'b0, 4'd0, '0, '0,
      ADR_X, 1'b1, DAT_C, ADR_Y, 1'b1, DAT_B},   // younger entry wins
    '{1'b0, 1'b0, 1'b1, 4'd3, ADR_Z, DAT_D, 1'b1, 4'd3, ADR_Z, DAT_E,
      ADR_Z, 1'b0, '0, ADR_X, 1'b1, DAT_C},
    '{1'b0, 1'b0, 1'b0, 4'd0, '0, '0, 1'b0, 4'd0, '0, '0,
      ADR_Z, 1'b1, DAT_E, ADR_X, 1'b1, DAT_C},   // port 1 data kept
    '{1'b0, 1'b1, 1'b0, 4'd0, '0, '0, 1'b0, 4'd0, '0, '0,
      ADR_Z, 1'b1, DAT_E, ADR_X, 1'b1, DAT_C},
    '{1'b0, 1'b1, 1'b0, 4'd0, '0, '0, 1'b0, 4'd0, '0, '0,
      ADR_Z, 1'b1, DAT_E, ADR_X, 1'b1, DAT_C},
    '{1'b0, 1'b1, 1'b0, 4'd0, '0, '0, 1'b0, 4'd0, '0, '0,
      ADR_Z, 1'b1, DAT_E, ADR_X, 1'b1, DAT_C},
    '{1'b0, 1'b0, 1'b0, 4'd0, '0, '0, 1'b0, 4'd0, '0, '0,
      ADR_Z, 1'b1, DAT_E, ADR_N, 1'b0, '0}
  };

  logic      clk;
  logic      rst_n;
  logic      alloc;
  stq_idx_t  alloc_idx;
  logic      full;
  logic      wr0_en;
  stq_idx_t  wr0_idx;
  stq_addr_t wr0_addr;
  stq_data_t wr0_data;
  logic      wr1_en;
  stq_idx_t  wr1_idx;
  stq_addr_t wr1_addr;
  stq_data_t wr1_data;
  logic      commit;
  stq_addr_t ld0_addr;
  logic      ld0_hit;
  stq_data_t ld0_data;
  stq_addr_t ld1_addr;
  logic      ld1_hit;
  stq_data_t ld1_data;
  logic      cache_valid;
  stq_addr_t cache_addr;
  stq_data_t cache_data;
  logic      cache_credit = 1'b0;

  stq_addr_t got_addr [$];  // stores seen by the cache model
  stq_data_t got_data [$];
  int        stores_seen = 0;
  int        credits_sent = 0;
  int        credit_limit = 1000000;  // lowered to hold credits back
  int        credit_wait = 0;
  int        errors = 0;
  int        checks = 0;
  int        tests_run = 0;
  int        tests_failed = 0;
  bit        aborted = 1'b0;

  stq_top DUT (
    .clk          (clk),
    .rst_n        (rst_n),
    .alloc        (alloc),
    .alloc_idx    (alloc_idx),
    .full         (full),
    .wr0_en       (wr0_en),
    .wr0_idx      (wr0_idx),
    .wr0_addr     (wr0_addr),
    .wr0_data     (wr0_data),
    .wr1_en       (wr1_en),
    .wr1_idx      (wr1_idx),
    .wr1_addr     (wr1_addr),
    .wr1_data     (wr1_data),
    .commit       (commit),
    .ld0_addr     (ld0_addr),
    .ld0_hit      (ld0_hit),
    .ld0_data     (ld0_data),
    .ld1_addr     (ld1_addr),
    .ld1_hit      (ld1_hit),
    .ld1_data     (ld1_data),
    .cache_valid  (cache_valid),
    .cache_addr   (cache_addr),
    .cache_data   (cache_data),
    .cache_credit (cache_credit)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // cache model, logs stores mid-cycle
  always @(negedge clk) begin
    if (rst_n && cache_valid) begin
      got_addr.push_back(cache_addr);
      got_data.push_back(cache_data);
      stores_seen++;
    end
  end

  // one credit back per logged store, after a random delay
  always @(posedge clk) begin
    cache_credit <= 1'b0;
    if (credit_wait > 0) begin
      credit_wait--;
    end else if (credits_sent < stores_seen && credits_sent < credit_limit) begin
      cache_credit <= 1'b1;
      credits_sent++;
      credit_wait = int'($urandom_range(3, 0));
    end
  end

  task automatic compare_data(input stq_data_t got, input stq_data_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic compare_addr(input stq_addr_t got, input stq_addr_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic compare_idx(input stq_idx_t got, input stq_idx_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic compare_hit(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  // idle a while, then the store count must not have moved
  task automatic hold_and_count(input int exp, input string what);
    repeat (10) @(negedge clk);
    checks++;
    if (got_addr.size() != exp) begin
      errors++;
      $display("mismatch at %0t: %s, %0d stores at the cache, expected %0d",
               $time, what, got_addr.size(), exp);
    end
  endtask

  task automatic wait_stores(input int n, input int limit);
    int cycles;
    cycles = 0;
    while (got_addr.size() < n && cycles < limit) begin
      @(negedge clk);
      cycles++;
    end
    if (got_addr.size() < n) begin
      errors++;
      aborted = 1'b1;
      $display("timeout: only %0d of %0d stores reached the cache", got_addr.size(), n);
    end
  endtask

  task automatic wait_not_full(input int limit);
    int cycles;
    cycles = 0;
    while (full && cycles < limit) begin
      @(negedge clk);
      cycles++;
    end
    if (full) begin
      errors++;
      aborted = 1'b1;
      $display("timeout: full stayed high after the head was committed");
    end
  endtask

  task automatic wait_credits_home(input int limit);
    int cycles;
    cycles = 0;
    while (credits_sent != stores_seen && cycles < limit) begin
      @(negedge clk);
      cycles++;
    end
    if (credits_sent != stores_seen) begin
      errors++;
      aborted = 1'b1;
      $display("timeout: cache model still owes %0d credits", stores_seen - credits_sent);
    end
  endtask

  task automatic finish_test(input string name, input int err_start);
    tests_run++;
    if (errors == err_start) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: FAILED with %0d errors", tests_run, name, errors - err_start);
    end
  endtask

  task automatic apply_row(input row_t r, input int n);
    @(posedge clk);
    alloc    <= r.alloc;
    commit   <= r.commit;
    wr0_en   <= r.wr0_en;
    wr0_idx  <= r.wr0_idx;
    wr0_addr <= r.wr0_addr;
    wr0_data <= r.wr0_data;
    wr1_en   <= r.wr1_en;
    wr1_idx  <= r.wr1_idx;
    wr1_addr <= r.wr1_addr;
    wr1_data <= r.wr1_data;
    ld0_addr <= r.ld0_addr;
    ld1_addr <= r.ld1_addr;
    @(negedge clk);
    compare_hit(ld0_hit, r.ld0_hit, $sformatf("row %0d ld0 hit", n));
    compare_data(ld0_data, r.ld0_data, $sformatf("row %0d ld0 data", n));
    compare_hit(ld1_hit, r.ld1_hit, $sformatf("row %0d ld1 hit", n));
    compare_data(ld1_data, r.ld1_data, $sformatf("row %0d ld1 data", n));
  endtask

  function automatic stq_addr_t burst_addr(input int k);
    return stq_addr_t'(32'h500 + k);
  endfunction

  function automatic stq_data_t burst_data(input int k);
    return stq_data_t'(32'h6000_0000 + k);
  endfunction

  task automatic test_reset();
    int err_start;
    err_start = errors;
    apply_row(rows[0], 0);
    compare_hit(full, 1'b0, "full after reset");
    compare_hit(cache_valid, 1'b0, "cache_valid after reset");
    compare_idx(alloc_idx, '0, "alloc_idx after reset");
    finish_test("reset state", err_start);
  endtask

  task automatic test_forwarding();
    int err_start;
    err_start = errors;
    for (int i = 1; i < NUM_ROWS; i++) begin
      apply_row(rows[i], i);
    end
    finish_test("forwarding table", err_start);
  endtask

  // entries 0..2 were committed by the table, entry 3 was not
  task automatic test_drain_order();
    int        err_start;
    stq_addr_t exp_addr [3];
    stq_data_t exp_data [3];
    err_start = errors;
    exp_addr = '{ADR_X, ADR_Y, ADR_X};
    exp_data = '{DAT_A, DAT_B, DAT_C};
    wait_stores(3, 20);
    if (!aborted) begin
      for (int k = 0; k < 3; k++) begin
        compare_addr(got_addr[k], exp_addr[k], $sformatf("drained store %0d address", k));
        compare_data(got_data[k], exp_data[k], $sformatf("drained store %0d data", k));
      end
      hold_and_count(3, "uncommitted store left the queue");
    end
    finish_test("drain order", err_start);
  endtask

  task automatic test_full();
    int err_start;
    int base;
    err_start = errors;
    base = got_addr.size();
    // entry 3 is still held, so one allocation short of the depth
    for (int k = 0; k < `STQ_ENTRIES - 1; k++) begin
      @(posedge clk);
      alloc <= 1'b1;
      @(negedge clk);
      compare_hit(full, 1'b0, $sformatf("full before allocation %0d", k));
      // the table already handed out entries 0..3
      compare_idx(alloc_idx, stq_idx_t'(4 + k), $sformatf("alloc_idx at allocation %0d", k));
    end
    @(posedge clk);
    alloc <= 1'b0;
    @(negedge clk);
    compare_hit(full, 1'b1, "full with every entry allocated");
    @(posedge clk);
    commit <= 1'b1;
    @(posedge clk);
    commit <= 1'b0;
    @(negedge clk);
    wait_not_full(10);
    if (!aborted) begin
      wait_stores(base + 1, 10);
    end
    if (!aborted) begin
      compare_addr(got_addr[base], ADR_Z, "head store address after full");
      compare_data(got_data[base], DAT_E, "head store data after full");
    end
    finish_test("full and drain", err_start);
  endtask

  task automatic test_credits();
    int err_start;
    int base;
    err_start = errors;
    base = got_addr.size();
    wait_credits_home(40);
    if (!aborted) begin
      credit_limit = credits_sent;
      for (int k = 0; k < 6; k += 2) begin
        @(posedge clk);
        wr0_en   <= 1'b1;
        wr0_idx  <= stq_idx_t'(4 + k);
        wr0_addr <= burst_addr(k);
        wr0_data <= burst_data(k);
        wr1_en   <= 1'b1;
        wr1_idx  <= stq_idx_t'(5 + k);
        wr1_addr <= burst_addr(k + 1);
        wr1_data <= burst_data(k + 1);
      end
      @(posedge clk);
      wr0_en <= 1'b0;
      wr1_en <= 1'b0;
      commit <= 1'b1;
      repeat (6) @(posedge clk);
      commit <= 1'b0;
      wait_stores(base + `STQ_DRAIN_CREDITS, 30);
      if (!aborted) begin
        hold_and_count(base + `STQ_DRAIN_CREDITS, "store sent without a credit");
      end
      for (int r = 1; r <= 2 && !aborted; r++) begin
        credit_limit++;  // hand back one slot
        wait_stores(base + `STQ_DRAIN_CREDITS + r, 30);
        if (!aborted) begin
          hold_and_count(base + `STQ_DRAIN_CREDITS + r, "one credit released extra stores");
        end
      end
      credit_limit = 1000000;
      if (!aborted) begin
        wait_credits_home(40);
      end
      if (!aborted) begin
        for (int k = 0; k < 6; k++) begin
          compare_addr(got_addr[base + k], burst_addr(k), $sformatf("burst %0d address", k));
          compare_data(got_data[base + k], burst_data(k), $sformatf("burst %0d data", k));
        end
      end
    end
    finish_test("credit back-pressure", err_start);
  endtask

  initial begin
    void'($urandom(32'hc3f2_951c));
    rst_n    <= 1'b0;
    alloc    <= 1'b0;
    commit   <= 1'b0;
    wr0_en   <= 1'b0;
    wr0_idx  <= '0;
    wr0_addr <= '0;
    wr0_data <= '0;
    wr1_en   <= 1'b0;
    wr1_idx  <= '0;
    wr1_addr <= '0;
    wr1_data <= '0;
    ld0_addr <= '0;
    ld1_addr <= '0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    test_reset();
    if (!aborted) test_forwarding();
    if (!aborted) test_drain_order();
    if (!aborted) test_full();
    if (!aborted) test_credits();

    $display("%0d tests run, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* sim.f */
+incdir+common
common/stq_pkg.sv
common/stq_drain_if.sv
stq/stq_data_array.sv
stq/stq_ctrl.sv
rtl/stq_drain.sv
rtl/stq_top.sv
verification/stq_tb.sv

/* Makefile */
SRCS := $(shell grep -v '^+' sim.f)

.PHONY: all run clean

all: run

obj_dir/Vstq_tb: sim.f $(SRCS) common/stq_config.svh
	verilator --binary --assert --top-module stq_tb -Mdir obj_dir -f sim.f

sim.log: obj_dir/Vstq_tb
	./obj_dir/Vstq_tb > sim.log 2>&1; cat sim.log

run: obj_dir/Vstq_tb
	./obj_dir/Vstq_tb > sim.log 2>&1; cat sim.log
	grep -qx 'All tests passed!' sim.log

clean:
	rm -rf obj_dir sim.log
